/* quote_order_tx.f */
rtl/itch_pkg.sv
rtl/quote_pkg.sv
rtl/order_if.sv
rtl/quote_dispatcher.sv
rtl/add_order_encoder.sv
rtl/order_word_serializer.sv
rtl/quote_order_tx.sv
testbench/tb_clock_gen.sv
testbench/quote_order_tx_properties.sv
testbench/order_checker.sv
testbench/quote_order_tx_tb.sv

/* rtl/add_order_encoder.sv */
`timescale 1ns/1ps

module add_order_encoder (
    input  logic                i_clk,
    input  logic                i_rst_n,
    order_if.dst                i_order,
    output logic                o_msg_valid,
    output itch_pkg::msg_bits_t o_msg
);

    quote_pkg::ticker_t  ticker;
    logic [7:0]          side_char;
    itch_pkg::word_t     words [itch_pkg::MSG_WORDS];
    logic                msg_valid_q;
    itch_pkg::msg_bits_t msg_q;

    // symbol to padded ascii ticker
    always_comb begin
        ticker = 64'h2020202020202020;
        case (i_order.symbol)
            quote_pkg::AAPL:  ticker = 64'h4141504c20202020;
            quote_pkg::AMZN:  ticker = 64'h414d5a4e20202020;
            quote_pkg::GOOGL: ticker = 64'h474f4f474c202020;
            quote_pkg::MSFT:  ticker = 64'h4d53465420202020;
            default:          ticker = 64'h2020202020202020;
        endcase
    end

    assign side_char = (i_order.side == quote_pkg::SELL) ? itch_pkg::SIDE_CHAR_SELL
                                                         : itch_pkg::SIDE_CHAR_BUY;

    // add order word layout
    always_comb begin
        words[0] = {i_order.tracking[7:0], i_order.locate, itch_pkg::MSG_TYPE_ADD};
        words[1] = {i_order.timestamp[23:0], i_order.tracking[15:8]};
        words[2] = {i_order.order_ref[7:0], i_order.timestamp[47:24]};
        words[3] = i_order.order_ref[39:8];
        words[4] = {i_order.order_ref[63:40], side_char};
        words[5] = i_order.quantity;
        words[6] = ticker[31:0];
        words[7] = ticker[63:32];
        words[8] = i_order.price;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            msg_valid_q <= 1'b0;
        end else begin
            msg_valid_q <= i_order.valid;
        end
    end

    // output register bank, loaded on the strobe
    always_ff @(posedge i_clk) begin
        if (i_order.valid) begin
            for (int w = 0; w < itch_pkg::MSG_WORDS; w++) begin
                msg_q[w*itch_pkg::WORD_BITS +: itch_pkg::WORD_BITS] <= words[w];
            end
        end
    end

    assign o_msg_valid = msg_valid_q;
    assign o_msg       = msg_q;

endmodule

/* rtl/itch_pkg.sv */
package itch_pkg;

    // one word on the output bus
    localparam int WORD_BITS = 32;
    typedef logic [WORD_BITS-1:0] word_t;

    // add order message length in words
    localparam int MSG_WORDS = 9;

    // whole message, word 0 in the low bits
    typedef logic [MSG_WORDS*WORD_BITS-1:0] msg_bits_t;

    // message type and side characters
    localparam logic [7:0] MSG_TYPE_ADD   = 8'h41;
    localparam logic [7:0] SIDE_CHAR_BUY  = 8'h42;
    localparam logic [7:0] SIDE_CHAR_SELL = 8'h53;

    // header fields
    typedef logic [15:0] locate_t;
    typedef logic [15:0] tracking_t;
    typedef logic [47:0] timestamp_t;

endpackage

/* rtl/order_if.sv */
`timescale 1ns/1ps

interface order_if;

    logic                   valid;
    quote_pkg::side_t       side;
    quote_pkg::price_t      price;
    quote_pkg::qty_t        quantity;
    quote_pkg::symbol_t     symbol;
    quote_pkg::order_ref_t  order_ref;
    itch_pkg::timestamp_t   timestamp;
    itch_pkg::locate_t      locate;
    itch_pkg::tracking_t    tracking;

    modport src (
        output valid, side, price, quantity, symbol,
        output order_ref, timestamp, locate, tracking
    );

    modport dst (
        input valid, side, price, quantity, symbol,
        input order_ref, timestamp, locate, tracking
    );

endinterface

/* rtl/order_word_serializer.sv */
`timescale 1ns/1ps

module order_word_serializer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [quote_pkg::NUM_SIDES-1:0] i_msg_valid,
    input  itch_pkg::msg_bits_t i_msg [quote_pkg::NUM_SIDES],
    output itch_pkg::word_t     o_word,
    output logic                o_word_valid,
    output logic                o_word_last,
    output logic                o_msg_done
);

    // buy words 0..8 then sell words 0..8
    localparam int TOTAL_WORDS = quote_pkg::NUM_SIDES * itch_pkg::MSG_WORDS;

    typedef enum logic {
        IDLE,
        SEND
    } state_t;

    state_t                 state_q;
    logic [TOTAL_WORDS-1:0] sel_q;
    itch_pkg::word_t        buf_q [TOTAL_WORDS];
    itch_pkg::word_t        word_mux;
    logic                   last_word;

    // one-hot select walks through all 18 words
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            sel_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (&i_msg_valid) begin
                        state_q <= SEND;
                        sel_q   <= {{(TOTAL_WORDS-1){1'b0}}, 1'b1};
                    end
                end
                SEND: begin
                    if (sel_q[TOTAL_WORDS-1]) begin
                        state_q <= IDLE;
                        sel_q   <= '0;
                    end else begin
                        sel_q <= sel_q << 1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                    sel_q   <= '0;
                end
            endcase
        end
    end

    // each side's message lands in its half of the buffer
    always_ff @(posedge i_clk) begin
        for (int s = 0; s < quote_pkg::NUM_SIDES; s++) begin
            if (i_msg_valid[s]) begin
                for (int w = 0; w < itch_pkg::MSG_WORDS; w++) begin
                    buf_q[s*itch_pkg::MSG_WORDS + w] <=
                        i_msg[s][w*itch_pkg::WORD_BITS +: itch_pkg::WORD_BITS];
                end
            end
        end
    end

    // and-or mux over the one-hot select
    always_comb begin
        word_mux = '0;
        for (int k = 0; k < TOTAL_WORDS; k++) begin
            if (sel_q[k]) begin
                word_mux = word_mux | buf_q[k];
            end
        end
    end

    assign last_word    = (state_q == SEND) && sel_q[TOTAL_WORDS-1];
    assign o_word       = word_mux;
    assign o_word_valid = (state_q == SEND);
    assign o_word_last  = last_word;
    assign o_msg_done   = last_word;

endmodule

/* rtl/quote_dispatcher.sv */
`timescale 1ns/1ps

module quote_dispatcher (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_quote_valid,
    input  quote_pkg::symbol_t    i_symbol,
    input  quote_pkg::price_t     i_buy_price,
    input  quote_pkg::price_t     i_sell_price,
    input  quote_pkg::qty_t       i_quantity,
    input  itch_pkg::locate_t     i_locate,
    input  itch_pkg::tracking_t   i_tracking,
    input  itch_pkg::timestamp_t  i_timestamp,
    input  logic                  i_msg_done,
    output logic                  o_busy,
    order_if.src                  o_order [quote_pkg::NUM_SIDES]
);

    // quote number n, the order refs are 2n and 2n+1
    localparam int CNT_W = $bits(quote_pkg::order_ref_t) - 1;

    logic                   busy_q;
    logic                   valid_q;
    logic                   done_q;
    logic                   accept;
    logic [CNT_W-1:0]       quote_cnt_q;

    quote_pkg::symbol_t     symbol_q;
    quote_pkg::qty_t        quantity_q;
    itch_pkg::locate_t      locate_q;
    itch_pkg::tracking_t    tracking_q;
    itch_pkg::timestamp_t   timestamp_q;
    quote_pkg::price_t      price_q [quote_pkg::NUM_SIDES];
    quote_pkg::order_ref_t  ref_q [quote_pkg::NUM_SIDES];

    assign accept = i_quote_valid && !busy_q;

    // busy falls on the edge after the last word
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_q      <= 1'b0;
            valid_q     <= 1'b0;
            done_q      <= 1'b0;
            quote_cnt_q <= '0;
        end else begin
            valid_q <= accept;
            done_q  <= i_msg_done;
            if (accept) begin
                busy_q      <= 1'b1;
                quote_cnt_q <= quote_cnt_q + 1'b1;
            end else if (done_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    // quote fields, meaningful only with the strobe
    always_ff @(posedge i_clk) begin
        if (accept) begin
            symbol_q    <= i_symbol;
            quantity_q  <= i_quantity;
            locate_q    <= i_locate;
            tracking_q  <= i_tracking;
            timestamp_q <= i_timestamp;
            price_q[0]  <= i_buy_price;
            price_q[1]  <= i_sell_price;
            ref_q[0]    <= {quote_cnt_q, 1'b0};
            ref_q[1]    <= {quote_cnt_q, 1'b1};
        end
    end

    assign o_busy = busy_q;

    for (genvar g = 0; g < quote_pkg::NUM_SIDES; g++) begin : g_side
        assign o_order[g].valid     = valid_q;
        assign o_order[g].side      = (g == 0) ? quote_pkg::BUY : quote_pkg::SELL;
        assign o_order[g].price     = price_q[g];
        assign o_order[g].quantity  = quantity_q;
        assign o_order[g].symbol    = symbol_q;
        assign o_order[g].order_ref = ref_q[g];
        assign o_order[g].timestamp = timestamp_q;
        assign o_order[g].locate    = locate_q;
        assign o_order[g].tracking  = tracking_q;
    end

endmodule

/* rtl/quote_order_tx.sv */
`timescale 1ns/1ps

module quote_order_tx (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_quote_valid,
    input  quote_pkg::symbol_t    i_symbol,
    input  quote_pkg::price_t     i_buy_price,
    input  quote_pkg::price_t     i_sell_price,
    input  quote_pkg::qty_t       i_quantity,
    input  itch_pkg::locate_t     i_locate,
    input  itch_pkg::tracking_t   i_tracking,
    input  itch_pkg::timestamp_t  i_timestamp,
    output logic                  o_busy,
    output itch_pkg::word_t       o_word,
    output logic                  o_word_valid,
    output logic                  o_word_last
);

    logic [quote_pkg::NUM_SIDES-1:0] msg_valid;
    itch_pkg::msg_bits_t             msg [quote_pkg::NUM_SIDES];
    logic                            msg_done;

    order_if order_bus [quote_pkg::NUM_SIDES] ();

    quote_dispatcher u_dispatcher (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_quote_valid (i_quote_valid),
        .i_symbol      (i_symbol),
        .i_buy_price   (i_buy_price),
        .i_sell_price  (i_sell_price),
        .i_quantity    (i_quantity),
        .i_locate      (i_locate),
        .i_tracking    (i_tracking),
        .i_timestamp   (i_timestamp),
        .i_msg_done    (msg_done),
        .o_busy        (o_busy),
        .o_order       (order_bus)
    );

    // one encoder per side
    for (genvar g = 0; g < quote_pkg::NUM_SIDES; g++) begin : g_enc
        add_order_encoder u_encoder (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_order     (order_bus[g]),
            .o_msg_valid (msg_valid[g]),
            .o_msg       (msg[g])
        );
    end

    order_word_serializer u_serializer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_msg_valid  (msg_valid),
        .i_msg        (msg),
        .o_word       (o_word),
        .o_word_valid (o_word_valid),
        .o_word_last  (o_word_last),
        .o_msg_done   (msg_done)
    );

endmodule

/* rtl/quote_pkg.sv */
package quote_pkg;

    typedef logic [31:0] price_t;
    typedef logic [31:0] qty_t;

    typedef enum logic [1:0] {
        AAPL  = 2'd0,
        AMZN  = 2'd1,
        GOOGL = 2'd2,
        MSFT  = 2'd3
    } symbol_t;

    typedef enum logic {
        BUY  = 1'b0,
        SELL = 1'b1
    } side_t;

    typedef logic [63:0] order_ref_t;

    // ascii, space padded, first character in the high byte
    typedef logic [63:0] ticker_t;

    // one order per side of a quote
    localparam int NUM_SIDES = 2;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the quote_order_tx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module quote_order_tx_tb \
    -f quote_order_tx.f -o sim_quote_order_tx

status=0
out=$(./obj_dir/sim_quote_order_tx) || status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    exit "$status"
fi
if printf '%s\n' "$out" | grep -qx 'TEST PASSED'; then
    exit 0
fi
exit 1

/* testbench/order_checker.sv */
`timescale 1ns/1ps

module order_checker (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_quote_valid,
    input  logic [1:0]  i_symbol,
    input  logic [31:0] i_buy_price,
    input  logic [31:0] i_sell_price,
    input  logic [31:0] i_quantity,
    input  logic [15:0] i_locate,
    input  logic [15:0] i_tracking,
    input  logic [47:0] i_timestamp,
    input  logic        i_busy,
    input  logic [31:0] i_word,
    input  logic        i_word_valid,
    input  logic        i_word_last,
    output int          o_errors,
    output int          o_accepted,
    output int          o_pending
);

    logic [31:0] exp_q [$];
    int          first_cycle_q [$];
    int          cycle = 0;
    int          word_idx = 0;
    int          errors = 0;
    int          accepted = 0;
    int          done = 0;
    int          quote_errs = 0;
    int          pending = 0;

    // ascii ticker, space padded, first character in the high byte
    function automatic logic [63:0] ticker_for(input logic [1:0] sym);
        case (sym)
            2'd0:    return "AAPL    ";
            2'd1:    return "AMZN    ";
            2'd2:    return "GOOGL   ";
            default: return "MSFT    ";
        endcase
    endfunction

    // nine words of one add order, fields taken from the accepting edge
    task automatic push_message(input logic [63:0] oref, input logic [7:0] side_ch,
                                input logic [31:0] price);
        logic [63:0] tick;
        tick = ticker_for(i_symbol);
        exp_q.push_back({i_tracking[7:0], i_locate, 8'h41});
        exp_q.push_back({i_timestamp[23:0], i_tracking[15:8]});
        exp_q.push_back({oref[7:0], i_timestamp[47:24]});
        exp_q.push_back(oref[39:8]);
        exp_q.push_back({oref[63:40], side_ch});
        exp_q.push_back(i_quantity);
        exp_q.push_back(tick[31:0]);
        exp_q.push_back(tick[63:32]);
        exp_q.push_back(price);
    endtask

    task automatic check_word();
        logic [31:0] want;
        if (exp_q.size() == 0) begin
            $display("word at %0t with no accepted quote outstanding", $time);
            errors++;
        end else begin
            want = exp_q.pop_front();
            if (word_idx == 0 && cycle != first_cycle_q[0]) begin
                $display("quote %0d: first word at cycle %0d, due at cycle %0d",
                         done, cycle, first_cycle_q[0]);
                quote_errs++;
            end
            if (i_word !== want) begin
                $display("FAILED %0t o_word expected %08h actual %08h (quote %0d word %0d)",
                         $time, want, i_word, done, word_idx);
                quote_errs++;
            end
            if (i_word_last !== (word_idx == 17)) begin
                $display("FAILED %0t o_word_last expected %0b actual %0b",
                         $time, word_idx == 17, i_word_last);
                quote_errs++;
            end
            word_idx++;
            if (word_idx == 18) begin
                $display("quote %0d: 18 words checked, %0d errors", done, quote_errs);
                errors += quote_errs;
                quote_errs = 0;
                word_idx = 0;
                void'(first_cycle_q.pop_front());
                done++;
            end
        end
    endtask

    // values sampled just before each rising edge
    always @(posedge i_clk) begin
        cycle++;
        if (i_rst_n) begin
            if (i_word_valid) begin
                check_word();
            end else if (word_idx != 0) begin
                $display("quote %0d: word stream stopped after %0d words", done, word_idx);
                errors += quote_errs + 1;
                quote_errs = 0;
                word_idx = 0;
                exp_q.delete();
                first_cycle_q.delete();
            end
            if (accepted == 0 && (i_busy || i_word_valid || i_word_last)) begin
                $display("outputs active at %0t before any quote was accepted", $time);
                errors++;
            end
            if (i_quote_valid && !i_busy) begin
                if (accepted == 0) begin
                    $display("idle after reset: finished, %0d errors", errors);
                end
                push_message(longint'(accepted) << 1, 8'h42, i_buy_price);
                push_message((longint'(accepted) << 1) | 64'd1, 8'h53, i_sell_price);
                first_cycle_q.push_back(cycle + 3);
                accepted++;
            end else if (i_quote_valid) begin
                $display("offer at %0t refused while busy", $time);
            end
        end
        pending = exp_q.size();
    end

    assign o_errors   = errors;
    assign o_accepted = accepted;
    assign o_pending  = pending;

endmodule

/* testbench/quote_order_tx_properties.sv */
`timescale 1ns/1ps

module quote_order_tx_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_busy,
    input logic i_word_valid,
    input logic i_word_last
);

    // consecutive cycles with a valid word so far
    logic [4:0] run_q;
    logic       rst_seen_q = 1'b0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            run_q <= '0;
        end else if (i_word_valid) begin
            run_q <= run_q + 5'd1;
        end else begin
            run_q <= '0;
        end
    end

    always @(posedge i_clk) begin
        rst_seen_q <= !i_rst_n;
    end

    a_last_has_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_word_last |-> i_word_valid) else $error("o_word_last without o_word_valid");

    a_valid_while_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_word_valid |-> i_busy) else $error("o_word_valid while o_busy low");

    a_last_is_18th: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_word_last |-> run_q == 5'd17) else $error("o_word_last not on the 18th word");

    a_burst_not_long: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_word_valid |-> run_q < 5'd18) else $error("word burst longer than 18");

    a_burst_not_short: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_word_valid && run_q != 5'd0) |-> run_q == 5'd18)
        else $error("word burst shorter than 18");

    a_quiet_in_reset: assert property (@(posedge i_clk)
        (!i_rst_n && rst_seen_q) |-> (!i_busy && !i_word_valid && !i_word_last))
        else $error("output active during reset");

endmodule

/* testbench/quote_order_tx_tb.sv */
`timescale 1ns/1ps

module quote_order_tx_tb;

    localparam string STIM_FILE  = "testbench/quote_stim.txt";
    localparam int    MAX_LINES  = 32;
    localparam int    PASSES     = 14;
    localparam int    WAIT_LIMIT = 100;

    logic               clk;
    logic               rst_n;
    logic               quote_valid;
    quote_pkg::symbol_t symbol;
    logic [31:0]        buy_price;
    logic [31:0]        sell_price;
    logic [31:0]        quantity;
    logic [15:0]        locate;
    logic [15:0]        tracking;
    logic [47:0]        timestamp;
    logic               busy;
    logic [31:0]        word;
    logic               word_valid;
    logic               word_last;
    int                 errors;
    int                 accepted;
    int                 pending;
    bit                 run_ok;

    // symbol, buy, sell, quantity, locate, tracking, timestamp
    logic [177:0]       stim_row [MAX_LINES];
    bit                 stim_wait [MAX_LINES];
    int                 stim_gap [MAX_LINES];
    int                 num_lines;
    int                 num_wait;

    tb_clock_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    quote_order_tx dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_quote_valid (quote_valid),
        .i_symbol      (symbol),
        .i_buy_price   (buy_price),
        .i_sell_price  (sell_price),
        .i_quantity    (quantity),
        .i_locate      (locate),
        .i_tracking    (tracking),
        .i_timestamp   (timestamp),
        .o_busy        (busy),
        .o_word        (word),
        .o_word_valid  (word_valid),
        .o_word_last   (word_last)
    );

    order_checker u_checker (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_quote_valid (quote_valid),
        .i_symbol      (symbol),
        .i_buy_price   (buy_price),
        .i_sell_price  (sell_price),
        .i_quantity    (quantity),
        .i_locate      (locate),
        .i_tracking    (tracking),
        .i_timestamp   (timestamp),
        .i_busy        (busy),
        .i_word        (word),
        .i_word_valid  (word_valid),
        .i_word_last   (word_last),
        .o_errors      (errors),
        .o_accepted    (accepted),
        .o_pending     (pending)
    );

    bind quote_order_tx quote_order_tx_properties u_props (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_busy       (o_busy),
        .i_word_valid (o_word_valid),
        .i_word_last  (o_word_last)
    );

    task automatic load_stim();
        int          fd;
        int          got;
        string       line;
        int          w;
        int          g;
        int          s;
        logic [31:0] bp;
        logic [31:0] sp;
        logic [31:0] qt;
        logic [15:0] lc;
        logic [15:0] tk;
        logic [47:0] ts;
        num_lines = 0;
        num_wait = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_lines < MAX_LINES) begin
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%d %d %d %h %h %h %h %h %h",
                                  w, g, s, bp, sp, qt, lc, tk, ts);
                    if (got == 9) begin
                        stim_wait[num_lines] = (w != 0);
                        stim_gap[num_lines]  = g;
                        stim_row[num_lines]  = {s[1:0], bp, sp, qt, lc, tk, ts};
                        num_wait += (w != 0) ? 1 : 0;
                        num_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_not_busy(output bit ok);
        int waited;
        waited = 0;
        while (busy && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        ok = !busy;
    endtask

    // one-cycle strobe, later passes shift timestamp and tracking
    task automatic offer_quote(input int k, input int pass);
        logic [1:0] sym;
        {sym, buy_price, sell_price, quantity, locate, tracking, timestamp} = stim_row[k];
        symbol      = quote_pkg::symbol_t'(sym);
        tracking    = tracking ^ 16'(pass);
        timestamp   = timestamp + (48'(pass) << 24);
        quote_valid = 1'b1;
        @(negedge clk);
        quote_valid = 1'b0;
    endtask

    initial begin
        bit ok;
        int gap;
        int waited;
        int offered;
        quote_valid = 1'b0;
        symbol      = quote_pkg::AAPL;
        buy_price   = '0;
        sell_price  = '0;
        quantity    = '0;
        locate      = '0;
        tracking    = '0;
        timestamp   = '0;
        run_ok      = 1'b1;
        offered     = 0;
        waited      = 0;
        void'($urandom(32'h1f1e54f7));
        load_stim();
        if (num_lines == 0) begin
            $display("no quotes read from %s", STIM_FILE);
            run_ok = 1'b0;
        end
        while (!rst_n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            run_ok = 1'b0;
        end
        // idle window checked by the checker
        repeat (8) @(negedge clk);
        for (int p = 0; p < PASSES && run_ok; p++) begin
            for (int k = 0; k < num_lines && run_ok; k++) begin
                if (stim_wait[k]) begin
                    wait_not_busy(ok);
                    if (!ok) begin
                        $display("o_busy stayed high for %0d cycles", WAIT_LIMIT);
                        run_ok = 1'b0;
                    end
                end
                if (run_ok) begin
                    offer_quote(k, p);
                    offered++;
                    gap = stim_gap[k] + int'($urandom % 3);
                    repeat (gap) @(negedge clk);
                end
            end
        end
        wait_not_busy(ok);
        if (!ok) begin
            $display("last transfer did not finish within %0d cycles", WAIT_LIMIT);
            run_ok = 1'b0;
        end
        repeat (2) @(negedge clk);
        if (pending != 0) begin
            $display("%0d expected words never appeared", pending);
            run_ok = 1'b0;
        end
        if (accepted != PASSES * num_wait) begin
            $display("%0d quotes accepted where %0d were due", accepted, PASSES * num_wait);
            run_ok = 1'b0;
        end
        $display("quotes offered %0d, accepted %0d, errors %0d", offered, accepted, errors);
        if (run_ok && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/quote_stim.txt */
# wait gap symbol buy_price sell_price quantity locate tracking timestamp
# wait 1 holds until o_busy is low, 0 offers at once; gap in idle cycles; the rest in hex
1 3 0 00BC614E 00BC6B12 00000064 0001 A1B2 0000DEADBEEF
0 2 1 00000001 00000002 00000003 0002 0003 000000000004
1 0 1 01312D00 01313A00 000003E8 0102 0203 123456789ABC
1 5 2 7FFFFFFF 80000000 FFFFFFFF FFFF FFFF FFFFFFFFFFFF
0 12 3 11111111 22222222 33333333 4444 5555 666666666666
1 1 3 0098967F 00989680 00000001 0000 0000 000000000000
1 2 0 000F4240 000F4241 00002710 00A5 5A00 A5A5A5A5A5A5
0 9 2 DEADBEEF CAFEF00D 0000BEEF 1234 4321 0F0E0D0C0B0A
1 0 2 00500000 00500100 00000200 0BAD F00D 800000000001
1 4 1 12345678 87654321 0000FFFF 7FFF 8000 00FF00FF00FF
1 0 0 00000000 FFFFFFFF 80000000 0001 0080 FF00FF00FF00
0 2 0 ABCDEF01 10FEDCBA 00000010 2222 3333 444444444444
1 6 3 00C0FFEE 00C0FFEF 00000064 0333 0444 0000000F4240
1 1 1 0000ABCD 0000ABCE 00000005 00FE 01FF 7FFFFFFFFFFF

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // release on a falling edge, like every other input
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule
